//--- hdl/slave_xlat_pkg.sv
// ------------------------------
// shared widths, types and default timing of the slave translator
// timing defaults must keep setup + write wait + hold below 16
// ------------------------------

package slave_xlat_pkg;

   // ------------------------------
   // bus widths
   // ------------------------------
   localparam int ADDR_W      = 32;   // host byte address
   localparam int DATA_W      = 32;
   localparam int BE_W        = DATA_W / 8;
   localparam int WORD_SHIFT  = 2;    // log2 of bytes per word
   localparam int WORD_ADDR_W = ADDR_W - WORD_SHIFT;

   typedef logic [ADDR_W-1:0]      byte_addr_t;
   typedef logic [WORD_ADDR_W-1:0] word_addr_t;
   typedef logic [DATA_W-1:0]      data_t;
   typedef logic [BE_W-1:0]        be_t;

   // ------------------------------
   // wait state counter
   // ------------------------------
   localparam int WAIT_CNT_W = 4;     // up to 15 cycles per request

   typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

   // default slave timing, in clock cycles
   localparam int DEF_SETUP_CYCLES      = 1;
   localparam int DEF_READ_WAIT_CYCLES  = 0;
   localparam int DEF_WRITE_WAIT_CYCLES = 1;
   localparam int DEF_HOLD_CYCLES       = 1;
   localparam int DEF_READ_LATENCY      = 3;   // at least 1

endpackage

//--- hdl/uav_req_if.sv
// ------------------------------
// host request as seen inside the translator
// read_accept is a one cycle strobe, no back-pressure
// ------------------------------

`timescale 1ns/100ps

interface uav_req_if;

   // host side request, held until waitrequest is low
   logic                      read;
   logic                      write;
   slave_xlat_pkg::byte_addr_t address;
   slave_xlat_pkg::be_t        byteenable;

   // read taken by the sequencer this cycle
   logic                      read_accept;

   // wait state sequencing and address translation
   modport seq (
      input  read,
      input  write,
      input  address,
      input  byteenable,
      output read_accept
   );

   // read latency tracking and chipselect
   modport track (
      input  read,
      input  write,
      input  read_accept
   );

endinterface

//--- hdl/transfer_sequencer.sv
// ------------------------------
// wait state generator for a fixed timing slave
// one request at a time, read and write never together
// total request length must stay below 16 cycles
// ------------------------------

`timescale 1ns/100ps

module transfer_sequencer #(
   parameter int SETUP_CYCLES      = slave_xlat_pkg::DEF_SETUP_CYCLES,
   parameter int READ_WAIT_CYCLES  = slave_xlat_pkg::DEF_READ_WAIT_CYCLES,
   parameter int WRITE_WAIT_CYCLES = slave_xlat_pkg::DEF_WRITE_WAIT_CYCLES,
   parameter int HOLD_CYCLES       = slave_xlat_pkg::DEF_HOLD_CYCLES
) (
   input  logic                       clk,
   input  logic                       reset,

   uav_req_if.seq                     req,

   output logic                       waitrequest,
   output logic                       av_read,
   output logic                       av_write,
   output logic                       av_begintransfer,
   output slave_xlat_pkg::word_addr_t av_address,
   output slave_xlat_pkg::be_t        av_writebyteenable
);

   // ------------------------------
   // count values that mark the phases
   // ------------------------------
   localparam slave_xlat_pkg::wait_cnt_t STROBE_START =
      slave_xlat_pkg::wait_cnt_t'(SETUP_CYCLES);
   localparam slave_xlat_pkg::wait_cnt_t WRITE_END =
      slave_xlat_pkg::wait_cnt_t'(SETUP_CYCLES + WRITE_WAIT_CYCLES);
   localparam slave_xlat_pkg::wait_cnt_t READ_DONE =
      slave_xlat_pkg::wait_cnt_t'(SETUP_CYCLES + READ_WAIT_CYCLES);
   localparam slave_xlat_pkg::wait_cnt_t WRITE_DONE =
      slave_xlat_pkg::wait_cnt_t'(SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES);

   slave_xlat_pkg::wait_cnt_t wait_cnt;   // cycles spent on current request
   logic                      reset_hold; // first cycle out of reset
   logic                      req_active;
   logic                      at_done;

   assign req_active = req.read | req.write;

   // write needs its hold cycles, read ends after the read wait
   assign at_done = req.write ? (wait_cnt == WRITE_DONE) : (wait_cnt == READ_DONE);

   assign waitrequest = reset_hold | ~at_done;

   // ------------------------------
   // wait state counter
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt   <= '0;
         reset_hold <= 1'b1;
      end else begin
         reset_hold <= 1'b0;
         if (reset_hold || !waitrequest) begin
            wait_cnt <= '0;             // accepted, next request starts at 0
         end else if (req_active) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0;
         end
      end
   end

   // ------------------------------
   // gated slave strobes
   // ------------------------------
   // read stays up from end of setup to acceptance
   assign av_read = req.read & ~reset_hold & (wait_cnt >= STROBE_START);

   // write drops again before the data hold cycles
   assign av_write = req.write & ~reset_hold &
                     (wait_cnt >= STROBE_START) & (wait_cnt <= WRITE_END);

   // count is zero only in the first cycle of a request
   assign av_begintransfer = req_active & ~reset_hold & (wait_cnt == '0);

   assign req.read_accept = req.read & ~waitrequest;

   // ------------------------------
   // address and byte enables
   // ------------------------------
   assign av_address = req.address[slave_xlat_pkg::ADDR_W-1:slave_xlat_pkg::WORD_SHIFT];

   assign av_writebyteenable = av_write ? req.byteenable : '0;

endmodule

//--- hdl/read_latency_tracker.sv
// ------------------------------
// fixed read latency tracking, several reads may be in flight
// READ_LATENCY must be 1 or more
// ------------------------------

`timescale 1ns/100ps

module read_latency_tracker #(
   parameter int READ_LATENCY = slave_xlat_pkg::DEF_READ_LATENCY
) (
   input  logic      clk,
   input  logic      reset,

   uav_req_if.track  req,

   output logic      readdatavalid,
   output logic      av_chipselect
);

   // one bit per cycle of latency, bit 0 is the newest read
   logic [READ_LATENCY-1:0] lat_sr;
   logic                    reads_pending;

   // ------------------------------
   // latency shift register
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         lat_sr <= '0;
      end else begin
         lat_sr[0] <= req.read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            lat_sr[i] <= lat_sr[i-1];
         end
      end
   end

   // slave data is valid when the oldest bit comes out
   assign readdatavalid = lat_sr[READ_LATENCY-1];

   // ------------------------------
   // chipselect extension
   // ------------------------------
   // includes the cycle in which the last data returns
   assign reads_pending = |lat_sr;

   assign av_chipselect = req.read | req.write | reads_pending;

endmodule

//--- hdl/avalon_slave_translator.sv
// ------------------------------
// universal Avalon-MM slave port to a fixed timing slave
// single word transfers only, no bursts, no waitrequest from slave
// slave readdata must be valid READ_LATENCY cycles after acceptance
// ------------------------------

`timescale 1ns/100ps

module avalon_slave_translator #(
   parameter int SETUP_CYCLES      = slave_xlat_pkg::DEF_SETUP_CYCLES,
   parameter int READ_WAIT_CYCLES  = slave_xlat_pkg::DEF_READ_WAIT_CYCLES,
   parameter int WRITE_WAIT_CYCLES = slave_xlat_pkg::DEF_WRITE_WAIT_CYCLES,
   parameter int HOLD_CYCLES       = slave_xlat_pkg::DEF_HOLD_CYCLES,
   parameter int READ_LATENCY      = slave_xlat_pkg::DEF_READ_LATENCY
) (
   input  logic                       clk,
   input  logic                       reset,

   // ------------------------------
   // host side
   // ------------------------------
   input  slave_xlat_pkg::byte_addr_t uav_address,
   input  slave_xlat_pkg::data_t      uav_writedata,
   input  slave_xlat_pkg::be_t        uav_byteenable,
   input  logic                       uav_read,
   input  logic                       uav_write,
   output logic                       uav_waitrequest,
   output slave_xlat_pkg::data_t      uav_readdata,
   output logic                       uav_readdatavalid,

   // ------------------------------
   // slave side
   // ------------------------------
   output slave_xlat_pkg::word_addr_t av_address,
   output slave_xlat_pkg::data_t      av_writedata,
   output slave_xlat_pkg::be_t        av_byteenable,
   output slave_xlat_pkg::be_t        av_writebyteenable,
   output logic                       av_read,
   output logic                       av_write,
   output logic                       av_begintransfer,
   output logic                       av_chipselect,
   input  slave_xlat_pkg::data_t      av_readdata
);

   uav_req_if req_if ();

   // host request into the internal bundle
   assign req_if.read       = uav_read;
   assign req_if.write      = uav_write;
   assign req_if.address    = uav_address;
   assign req_if.byteenable = uav_byteenable;

   // data paths need no timing of their own
   assign av_writedata  = uav_writedata;
   assign av_byteenable = uav_byteenable;
   assign uav_readdata  = av_readdata;   // qualified by readdatavalid

   // ------------------------------
   // wait states and strobes
   // ------------------------------
   transfer_sequencer #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES)
   ) i_seq (
      .clk                (clk),
      .reset              (reset),
      .req                (req_if.seq),
      .waitrequest        (uav_waitrequest),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_begintransfer   (av_begintransfer),
      .av_address         (av_address),
      .av_writebyteenable (av_writebyteenable)
   );

   // ------------------------------
   // read return and chipselect
   // ------------------------------
   read_latency_tracker #(
      .READ_LATENCY (READ_LATENCY)
   ) i_track (
      .clk           (clk),
      .reset         (reset),
      .req           (req_if.track),
      .readdatavalid (uav_readdatavalid),
      .av_chipselect (av_chipselect)
   );

endmodule

//--- verif/xfer_checker.sv
// ------------------------------
// watches the translator ports and compares against the slave timing rules
// expected read data arrives on exp_rdata while the read is held
// samples on the falling edge only
// ------------------------------

`timescale 1ns/100ps

module xfer_checker #(
   parameter int SETUP_CYCLES      = slave_xlat_pkg::DEF_SETUP_CYCLES,
   parameter int READ_WAIT_CYCLES  = slave_xlat_pkg::DEF_READ_WAIT_CYCLES,
   parameter int WRITE_WAIT_CYCLES = slave_xlat_pkg::DEF_WRITE_WAIT_CYCLES,
   parameter int HOLD_CYCLES       = slave_xlat_pkg::DEF_HOLD_CYCLES,
   parameter int READ_LATENCY      = slave_xlat_pkg::DEF_READ_LATENCY
) (
   input  logic                       clk,
   input  logic                       reset,
   input  slave_xlat_pkg::byte_addr_t uav_address,
   input  slave_xlat_pkg::data_t      uav_writedata,
   input  slave_xlat_pkg::be_t        uav_byteenable,
   input  logic                       uav_read,
   input  logic                       uav_write,
   input  logic                       uav_waitrequest,
   input  slave_xlat_pkg::data_t      uav_readdata,
   input  logic                       uav_readdatavalid,
   input  slave_xlat_pkg::word_addr_t av_address,
   input  slave_xlat_pkg::data_t      av_writedata,
   input  slave_xlat_pkg::be_t        av_byteenable,
   input  slave_xlat_pkg::be_t        av_writebyteenable,
   input  logic                       av_read,
   input  logic                       av_write,
   input  logic                       av_begintransfer,
   input  logic                       av_chipselect,
   input  slave_xlat_pkg::data_t      exp_rdata,
   output int                         mismatch_count,
   output int                         other_count,
   output int                         reads_checked
);

   slave_xlat_pkg::data_t exp_q[$];   // read data still owed to the host
   int                    due_q[$];   // cycle in which each read returns
   int                    cyc;
   int                    req_cyc;    // position inside the held request
   logic                  was_reset;

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
      if (got !== expected) begin
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, expected);
         mismatch_count++;
      end
   endtask

   always @(negedge clk) begin : watch
      logic req_held;
      logic cs_exp;
      logic wait_exp;
      logic rd_exp;
      logic wr_exp;
      int   done_at;

      if (reset) begin
         exp_q.delete();
         due_q.delete();
         cyc            = 0;
         req_cyc        = 0;
         was_reset      = 1'b1;
         mismatch_count = 0;
         other_count    = 0;
         reads_checked  = 0;
      end else begin
         req_held = uav_read | uav_write;
         cs_exp   = req_held | (due_q.size() != 0);   // before this cycle's return

         // ------------------------------
         // request phase
         // ------------------------------
         if (was_reset) begin
            compare_value("uav_waitrequest", 32'(uav_waitrequest), 32'd1);
            compare_value("av_read", 32'(av_read), 32'd0);
            compare_value("av_write", 32'(av_write), 32'd0);
            compare_value("av_begintransfer", 32'(av_begintransfer), 32'd0);
            if (req_held) begin
               $display("ERROR at %0t: request driven in the first cycle after reset", $time);
               other_count++;
            end
         end else if (req_held) begin
            done_at  = uav_write ? SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES
                                 : SETUP_CYCLES + READ_WAIT_CYCLES;
            rd_exp   = uav_read && (req_cyc >= SETUP_CYCLES);
            wr_exp   = uav_write && (req_cyc >= SETUP_CYCLES) &&
                       (req_cyc <= SETUP_CYCLES + WRITE_WAIT_CYCLES);
            wait_exp = (req_cyc != done_at);
            compare_value("uav_waitrequest", 32'(uav_waitrequest), 32'(wait_exp));
            compare_value("av_read", 32'(av_read), 32'(rd_exp));
            compare_value("av_write", 32'(av_write), 32'(wr_exp));
            compare_value("av_begintransfer", 32'(av_begintransfer), 32'(req_cyc == 0));
            compare_value("av_address", 32'(av_address),
                          32'(uav_address >> slave_xlat_pkg::WORD_SHIFT));
            compare_value("av_writedata", av_writedata, uav_writedata);   // straight through
            compare_value("av_byteenable", 32'(av_byteenable), 32'(uav_byteenable));
            compare_value("av_writebyteenable", 32'(av_writebyteenable),
                          wr_exp ? 32'(uav_byteenable) : 32'd0);
            if (!uav_waitrequest) begin
               if (uav_read) begin
                  exp_q.push_back(exp_rdata);
                  due_q.push_back(cyc + READ_LATENCY);
               end
               req_cyc = 0;
            end else begin
               req_cyc++;
            end
         end else begin
            compare_value("av_read", 32'(av_read), 32'd0);
            compare_value("av_write", 32'(av_write), 32'd0);
            compare_value("av_begintransfer", 32'(av_begintransfer), 32'd0);
            compare_value("av_writebyteenable", 32'(av_writebyteenable), 32'd0);
            req_cyc = 0;
         end

         // ------------------------------
         // read return and chipselect
         // ------------------------------
         if (due_q.size() != 0 && due_q[0] == cyc) begin
            compare_value("uav_readdatavalid", 32'(uav_readdatavalid), 32'd1);
            compare_value("uav_readdata", uav_readdata, exp_q[0]);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
            reads_checked++;
         end else begin
            compare_value("uav_readdatavalid", 32'(uav_readdatavalid), 32'd0);
         end
         compare_value("av_chipselect", 32'(av_chipselect), 32'(cs_exp));

         cyc++;
         was_reset = 1'b0;
      end
   end

endmodule

//--- verif/tb_slave_translator.sv
// ------------------------------
// testbench for the slave translator with default timing
// slave memory decodes only the low 4 word address bits
// ------------------------------

`timescale 1ns/100ps

module tb_slave_translator;

   typedef struct packed {
      logic                       is_write;
      logic                       no_gap;     // issue right after the previous one
      slave_xlat_pkg::byte_addr_t addr;
      slave_xlat_pkg::data_t      wdata;
      slave_xlat_pkg::be_t        be;
      slave_xlat_pkg::data_t      exp_data;   // reads only
   } entry_t;

   localparam int NUM_STIM       = 14;
   localparam int TIMEOUT_CYCLES = NUM_STIM * 10 + 50;
   localparam int READ_LAT       = slave_xlat_pkg::DEF_READ_LATENCY;
   localparam int MEM_WORDS      = 16;

   // expected words are the byte merge of the earlier writes
   localparam entry_t STIM [NUM_STIM] = '{
      '{1'b1, 1'b0, 32'h1000_0000, 32'h1122_3344, 4'hf, 32'h0},
      '{1'b1, 1'b0, 32'h1000_0004, 32'h5566_7788, 4'hf, 32'h0},
      '{1'b1, 1'b0, 32'h2000_0008, 32'h99aa_bbcc, 4'hf, 32'h0},
      '{1'b1, 1'b0, 32'h1000_0004, 32'hdead_beef, 4'h5, 32'h0},
      '{1'b0, 1'b0, 32'h1000_0000, 32'h0,         4'hf, 32'h1122_3344},
      '{1'b0, 1'b1, 32'h1000_0004, 32'h0,         4'hf, 32'h55ad_77ef},
      '{1'b0, 1'b1, 32'h2000_0008, 32'h0,         4'hf, 32'h99aa_bbcc},
      '{1'b1, 1'b0, 32'h3000_000c, 32'hcafe_f00d, 4'hf, 32'h0},
      '{1'b1, 1'b0, 32'h3000_000e, 32'h0102_0304, 4'hc, 32'h0},
      '{1'b0, 1'b0, 32'h3000_000d, 32'h0,         4'hf, 32'h0102_f00d},
      '{1'b0, 1'b1, 32'h1000_0000, 32'h0,         4'hf, 32'h1122_3344},
      '{1'b1, 1'b0, 32'h2000_0008, 32'h0000_0000, 4'h2, 32'h0},
      '{1'b0, 1'b0, 32'h2000_0008, 32'h0,         4'hf, 32'h99aa_00cc},
      '{1'b0, 1'b1, 32'h1000_0004, 32'h0,         4'hf, 32'h55ad_77ef}
   };

   logic                       clk;
   logic                       reset;
   slave_xlat_pkg::byte_addr_t uav_address;
   slave_xlat_pkg::data_t      uav_writedata;
   slave_xlat_pkg::be_t        uav_byteenable;
   logic                       uav_read;
   logic                       uav_write;
   logic                       uav_waitrequest;
   slave_xlat_pkg::data_t      uav_readdata;
   logic                       uav_readdatavalid;
   slave_xlat_pkg::word_addr_t av_address;
   slave_xlat_pkg::data_t      av_writedata;
   slave_xlat_pkg::be_t        av_byteenable;
   slave_xlat_pkg::be_t        av_writebyteenable;
   logic                       av_read;
   logic                       av_write;
   logic                       av_begintransfer;
   logic                       av_chipselect;
   slave_xlat_pkg::data_t      av_readdata;
   slave_xlat_pkg::data_t      exp_rdata;
   int                         mismatch_count;
   int                         other_count;
   int                         reads_checked;
   logic [31:0]                lfsr;

   slave_xlat_pkg::data_t      mem [MEM_WORDS];
   slave_xlat_pkg::data_t      rd_pipe [READ_LAT];
   logic [3:0]                 mem_idx;

   avalon_slave_translator i_dut (
      .clk                (clk),
      .reset              (reset),
      .uav_address        (uav_address),
      .uav_writedata      (uav_writedata),
      .uav_byteenable     (uav_byteenable),
      .uav_read           (uav_read),
      .uav_write          (uav_write),
      .uav_waitrequest    (uav_waitrequest),
      .uav_readdata       (uav_readdata),
      .uav_readdatavalid  (uav_readdatavalid),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_byteenable      (av_byteenable),
      .av_writebyteenable (av_writebyteenable),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_begintransfer   (av_begintransfer),
      .av_chipselect      (av_chipselect),
      .av_readdata        (av_readdata)
   );

   xfer_checker i_chk (
      .clk                (clk),
      .reset              (reset),
      .uav_address        (uav_address),
      .uav_writedata      (uav_writedata),
      .uav_byteenable     (uav_byteenable),
      .uav_read           (uav_read),
      .uav_write          (uav_write),
      .uav_waitrequest    (uav_waitrequest),
      .uav_readdata       (uav_readdata),
      .uav_readdatavalid  (uav_readdatavalid),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_byteenable      (av_byteenable),
      .av_writebyteenable (av_writebyteenable),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_begintransfer   (av_begintransfer),
      .av_chipselect      (av_chipselect),
      .exp_rdata          (exp_rdata),
      .mismatch_count     (mismatch_count),
      .other_count        (other_count),
      .reads_checked      (reads_checked)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ------------------------------
   // slave memory model
   // ------------------------------
   assign mem_idx     = av_address[3:0];
   assign av_readdata = reset ? '0 : rd_pipe[READ_LAT-1];

   always @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= {16'h5a5a, 16'(i)};   // fill keyed on the word index
         end
         for (int k = 0; k < READ_LAT; k++) begin
            rd_pipe[k] <= '0;
         end
      end else begin
         if (av_write) begin
            for (int b = 0; b < slave_xlat_pkg::BE_W; b++) begin
               if (av_writebyteenable[b]) begin
                  mem[mem_idx][8*b +: 8] <= av_writedata[8*b +: 8];
               end
            end
         end
         rd_pipe[0] <= (av_read && !uav_waitrequest) ? mem[mem_idx] : '0;
         for (int k = 1; k < READ_LAT; k++) begin
            rd_pipe[k] <= rd_pipe[k-1];
         end
      end
   end

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_gap(output int gap);
      logic [1:0] bits;
      for (int k = 0; k < 2; k++) begin
         bits[k] = lfsr[0];
         lfsr    = lfsr_next(lfsr);
      end
      gap = int'(bits);
   endtask

   task automatic go_idle();
      uav_read       <= 1'b0;
      uav_write      <= 1'b0;
      uav_address    <= '0;
      uav_writedata  <= '0;
      uav_byteenable <= '0;
      exp_rdata      <= '0;
   endtask

   task automatic issue_request(input entry_t e);
      uav_read       <= !e.is_write;
      uav_write      <= e.is_write;
      uav_address    <= e.addr;
      uav_writedata  <= e.wdata;
      uav_byteenable <= e.be;
      exp_rdata      <= e.exp_data;
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      int gap;
      int num_reads;
      int tb_errors;

      reset          = 1'b1;
      uav_read       = 1'b0;
      uav_write      = 1'b0;
      uav_address    = '0;
      uav_writedata  = '0;
      uav_byteenable = '0;
      exp_rdata      = '0;
      lfsr           = 32'hf40fc1c0;
      num_reads      = 0;
      tb_errors      = 0;

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      for (int n = 0; n < NUM_STIM; n++) begin
         if (STIM[n].no_gap) begin
            gap = 0;
         end else begin
            draw_gap(gap);
         end
         repeat (gap) begin
            @(posedge clk);
            go_idle();
         end
         @(posedge clk);
         issue_request(STIM[n]);
         do @(negedge clk); while (uav_waitrequest);   // held until accepted
         if (!STIM[n].is_write) num_reads++;
      end
      @(posedge clk);
      go_idle();

      // drain the reads still in flight
      do @(negedge clk); while (av_chipselect);
      repeat (2) @(posedge clk);

      if (reads_checked != num_reads) begin
         $display("ERROR: %0d of %0d reads returned data", reads_checked, num_reads);
         tb_errors++;
      end
      $display("%0d mismatches, %0d other errors", mismatch_count, other_count + tb_errors);
      if (mismatch_count == 0 && other_count == 0 && tb_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // ------------------------------
   // timeout
   // ------------------------------
   initial begin
      int cycle_cnt;
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
   end

endmodule

//--- tb.f
hdl/slave_xlat_pkg.sv
hdl/uav_req_if.sv
hdl/transfer_sequencer.sv
hdl/read_latency_tracker.sv
hdl/avalon_slave_translator.sv
verif/xfer_checker.sv
verif/tb_slave_translator.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the slave translator testbench with Verilator and runs it
# exit status is nonzero unless the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --timescale 1ns/100ps \
   --top-module tb_slave_translator \
   -f tb.f \
   && ./obj_dir/Vtb_slave_translator | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
